// File: thread_manager.f
thread_mgr_pkg.sv
thread_entry_if.sv
thread_cmd_decoder.sv
pending_queue.sv
active_table.sv
thread_dispatcher.sv
thread_manager.sv
thread_manager_properties.sv
thread_manager_tb.sv

// File: Bender.yml
package:
  name: thread_manager

sources:
  - thread_mgr_pkg.sv
  - thread_entry_if.sv
  - thread_cmd_decoder.sv
  - pending_queue.sv
  - active_table.sv
  - thread_dispatcher.sv
  - thread_manager.sv
  - target: simulation
    files:
      - thread_manager_properties.sv
      - thread_manager_tb.sv

// File: thread_manager_tb.sv
`timescale 1ns/1ps
`default_nettype none

module thread_manager_tb;

  logic clk;
  logic rst;
  logic [7:0] ctl_state_i;
  logic [3:0] thrd_cmd_i;
  logic [thread_mgr_pkg::DATA_W-1:0] data_i;
  logic [thread_mgr_pkg::ADDR_W-1:0] addr_i;
  logic [1:0] thrd_rslt_o;
  logic [thread_mgr_pkg::DATA_W-1:0] result_data_o;
  logic [thread_mgr_pkg::ADDR_W-1:0] next_proc_o;
  logic [thread_mgr_pkg::DATA_W-1:0] next_state_o;
  logic dispatch_o;
  integer seed;

  logic q_stop [$];  // Reference pending FIFO.
  logic [thread_mgr_pkg::DATA_W-1:0] q_state [$];
  logic [thread_mgr_pkg::ADDR_W-1:0] q_addr [$];
  logic [thread_mgr_pkg::PROC_QUANTITY-1:0] m_valid;  // Reference active table.
  logic [thread_mgr_pkg::DATA_W-1:0] m_state [thread_mgr_pkg::PROC_QUANTITY];
  logic [thread_mgr_pkg::ADDR_W-1:0] m_addr [thread_mgr_pkg::PROC_QUANTITY];
  int m_last;
  logic m_ready;
  logic m_live = 1'b0;
  logic [1:0] exp_rslt;
  logic [thread_mgr_pkg::DATA_W-1:0] exp_data;
  logic [thread_mgr_pkg::ADDR_W-1:0] exp_proc;
  logic [thread_mgr_pkg::DATA_W-1:0] exp_state;
  logic exp_dispatch;

  thread_manager i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first error.");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    stop_on_failure($sformatf("Fail at %0t: %s expected %0h, actual %0h", $time, name,
                              exp_v, act_v));
  endtask

  task automatic check_rslt(input logic [1:0] code,
                            input logic [thread_mgr_pkg::DATA_W-1:0] word);
    if (thrd_rslt_o !== code) report_mismatch("thrd_rslt_o", 32'(code), 32'(thrd_rslt_o));
    if (code != thread_mgr_pkg::RSLT_NONE && result_data_o !== word) begin
      report_mismatch("result_data_o", word, result_data_o);
    end
  endtask

  task automatic check_dispatch(input logic [thread_mgr_pkg::ADDR_W-1:0] proc,
                                input logic [thread_mgr_pkg::DATA_W-1:0] state,
                                input logic pulse);
    if (dispatch_o !== pulse) report_mismatch("dispatch_o", 32'(pulse), 32'(dispatch_o));
    if (next_proc_o !== proc) report_mismatch("next_proc_o", 32'(proc), 32'(next_proc_o));
    if (next_state_o !== state) report_mismatch("next_state_o", state, next_state_o);
  endtask

  // Outputs expected after one clock edge, from the inputs sampled at that edge.
  function automatic void predict_cycle(input logic [7:0] ctl, input logic [3:0] cmd,
                                        input logic [thread_mgr_pkg::DATA_W-1:0] data,
                                        input logic [thread_mgr_pkg::ADDR_W-1:0] addr);
    int free_slot;
    int pick_slot;
    logic decide;
    free_slot = -1;
    pick_slot = -1;
    decide = m_ready && ctl == thread_mgr_pkg::CTL_CPU_LOOP;
    for (int i = 0; i < thread_mgr_pkg::PROC_QUANTITY; i++) begin
      if (free_slot < 0 && !m_valid[i]) free_slot = i;
      if (pick_slot < 0 && m_valid[(m_last + 1 + i) % thread_mgr_pkg::PROC_QUANTITY]) begin
        pick_slot = (m_last + 1 + i) % thread_mgr_pkg::PROC_QUANTITY;
      end
    end
    exp_rslt = thread_mgr_pkg::RSLT_NONE;
    exp_dispatch = 1'b0;
    if (ctl == thread_mgr_pkg::CTL_CPU_CMD && (cmd == thread_mgr_pkg::THREAD_CMD_RUN ||
        cmd == thread_mgr_pkg::THREAD_CMD_STOP)) begin
      if (q_addr.size() < thread_mgr_pkg::PROC_QUANTITY) begin
        q_stop.push_back(cmd == thread_mgr_pkg::THREAD_CMD_STOP);
        q_state.push_back(cmd == thread_mgr_pkg::THREAD_CMD_STOP ? '0 : data);
        q_addr.push_back(addr);
        exp_rslt = thread_mgr_pkg::RSLT_ACCEPTED;
        exp_data = thread_mgr_pkg::STATE_ACK;
      end else begin
        exp_rslt = thread_mgr_pkg::RSLT_REJECTED;
        exp_data = thread_mgr_pkg::STATE_NACK;
      end
    end
    if (decide && q_addr.size() != 0 && (q_stop[0] || free_slot >= 0)) begin
      if (q_stop[0]) begin
        for (int i = 0; i < thread_mgr_pkg::PROC_QUANTITY; i++) begin
          if (m_valid[i] && m_addr[i] == q_addr[0]) m_valid[i] = 1'b0;
        end
      end else begin
        m_valid[free_slot] = 1'b1;
        m_state[free_slot] = q_state[0];
        m_addr[free_slot] = q_addr[0];
        exp_proc = q_addr[0];
        exp_state = q_state[0];
        exp_dispatch = 1'b1;
      end
      q_stop.delete(0);
      q_state.delete(0);
      q_addr.delete(0);
    end else if (decide && pick_slot >= 0) begin
      m_last = pick_slot;
      exp_proc = m_addr[pick_slot];
      exp_state = m_state[pick_slot];
      exp_dispatch = 1'b1;
    end
    m_ready = !decide && (m_ready || cmd == thread_mgr_pkg::THREAD_CMD_GET_NEXT);
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      q_stop.delete();
      q_state.delete();
      q_addr.delete();
      m_valid = '0;
      m_last = thread_mgr_pkg::PROC_QUANTITY - 1;
      m_ready = 1'b1;
      exp_rslt = thread_mgr_pkg::RSLT_NONE;
      exp_proc = '0;
      exp_state = '0;
      exp_dispatch = 1'b0;
      m_live = 1'b1;
    end else if (m_live) begin
      predict_cycle(ctl_state_i, thrd_cmd_i, data_i, addr_i);
    end
  end

  always @(negedge clk) begin
    if (m_live) begin  // Outputs settle well before the falling edge.
      check_rslt(exp_rslt, exp_data);
      check_dispatch(exp_proc, exp_state, exp_dispatch);
    end
  end

  task automatic drive(input logic [7:0] ctl, input logic [3:0] cmd,
                       input logic [thread_mgr_pkg::DATA_W-1:0] data,
                       input logic [thread_mgr_pkg::ADDR_W-1:0] addr);
    @(posedge clk);
    #1;
    ctl_state_i = ctl;
    thrd_cmd_i = cmd;
    data_i = data;
    addr_i = addr;
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  task automatic send_cmd(input logic [3:0] cmd, input logic [thread_mgr_pkg::ADDR_W-1:0] addr,
                          input logic [thread_mgr_pkg::DATA_W-1:0] state,
                          input logic [1:0] code);
    drive(thread_mgr_pkg::CTL_CPU_CMD, cmd, state, addr);
    drive(8'h00, 4'h0, '0, '0);
    check_rslt(code, code == thread_mgr_pkg::RSLT_ACCEPTED ? thread_mgr_pkg::STATE_ACK :
               thread_mgr_pkg::STATE_NACK);
  endtask

  task automatic request_next();
    drive(8'h00, thread_mgr_pkg::THREAD_CMD_GET_NEXT, '0, '0);
    drive(thread_mgr_pkg::CTL_CPU_LOOP, 4'h0, '0, '0);
  endtask

  task automatic expect_dispatch(input logic [thread_mgr_pkg::ADDR_W-1:0] proc,
                                 input logic [thread_mgr_pkg::DATA_W-1:0] state);
    int waited;
    waited = 0;
    request_next();
    drive(8'h00, 4'h0, '0, '0);
    while (dispatch_o !== 1'b1) begin
      if (waited == 8) stop_on_failure("Timeout: GET_NEXT in the loop state gave no dispatch");
      waited++;
      drive(8'h00, 4'h0, '0, '0);
    end
    check_dispatch(proc, state, 1'b1);
  endtask

  initial begin
    logic [31:0] r;
    logic [7:0] ctl;
    logic [3:0] cmd;
    seed = 32'h4198b52e;
    ctl_state_i = 8'h00;
    thrd_cmd_i = 4'h0;
    data_i = '0;
    addr_i = '0;
    apply_reset();
    check_rslt(thread_mgr_pkg::RSLT_NONE, '0);
    check_dispatch('0, '0, 1'b0);
    request_next();  // Empty tables.
    repeat (3) drive(8'h00, 4'h0, '0, '0);
    for (int i = 0; i < thread_mgr_pkg::PROC_QUANTITY; i++) begin
      send_cmd(thread_mgr_pkg::THREAD_CMD_RUN, 16'h0100 + 16'(i), 32'ha000_0000 + 32'(i),
               thread_mgr_pkg::RSLT_ACCEPTED);
    end
    send_cmd(thread_mgr_pkg::THREAD_CMD_RUN, 16'h01ff, 32'h1, thread_mgr_pkg::RSLT_REJECTED);
    for (int i = 0; i < thread_mgr_pkg::PROC_QUANTITY; i++) begin
      expect_dispatch(16'h0100 + 16'(i), 32'ha000_0000 + 32'(i));  // Oldest first.
    end
    for (int i = 0; i <= thread_mgr_pkg::PROC_QUANTITY; i++) begin
      expect_dispatch(16'h0100 + 16'(i % 8), 32'ha000_0000 + 32'(i % 8));  // Wraps to slot 0.
    end
    send_cmd(thread_mgr_pkg::THREAD_CMD_STOP, 16'h0103, '0, thread_mgr_pkg::RSLT_ACCEPTED);
    request_next();
    repeat (3) drive(8'h00, 4'h0, '0, '0);
    send_cmd(thread_mgr_pkg::THREAD_CMD_RUN, 16'h0300, 32'hc000_0000,
             thread_mgr_pkg::RSLT_ACCEPTED);
    expect_dispatch(16'h0300, 32'hc000_0000);  // Lands in freed slot 3.
    expect_dispatch(16'h0101, 32'ha000_0001);
    expect_dispatch(16'h0102, 32'ha000_0002);
    expect_dispatch(16'h0300, 32'hc000_0000);
    expect_dispatch(16'h0104, 32'ha000_0004);
    // Table is full again. The STOP frees slot 7 for the first RUN
    // while the second RUN stays queued behind the picks.
    send_cmd(thread_mgr_pkg::THREAD_CMD_STOP, 16'h0107, '0, thread_mgr_pkg::RSLT_ACCEPTED);
    send_cmd(thread_mgr_pkg::THREAD_CMD_RUN, 16'h0400, 32'hd000_0000,
             thread_mgr_pkg::RSLT_ACCEPTED);
    send_cmd(thread_mgr_pkg::THREAD_CMD_RUN, 16'h0401, 32'hd000_0001,
             thread_mgr_pkg::RSLT_ACCEPTED);
    request_next();
    repeat (3) drive(8'h00, 4'h0, '0, '0);
    expect_dispatch(16'h0400, 32'hd000_0000);
    expect_dispatch(16'h0105, 32'ha000_0005);
    expect_dispatch(16'h0106, 32'ha000_0006);
    expect_dispatch(16'h0400, 32'hd000_0000);  // Slot 7 holds the promoted RUN.
    apply_reset();
    repeat (500) begin
      r = $random(seed);
      ctl = (r[1:0] == 2'd0) ? 8'h00 :
            (r[1:0] == 2'd1) ? thread_mgr_pkg::CTL_CPU_LOOP : thread_mgr_pkg::CTL_CPU_CMD;
      cmd = {2'b00, r[3:2]};
      drive(ctl, cmd, $random(seed), 16'h0500 + 16'(r[6:4]));
    end
    repeat (4) drive(8'h00, 4'h0, '0, '0);
    if (i_dut.i_props.error_count != 0) begin
      stop_on_failure("Concurrent assertions reported errors during the run");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: thread_manager_properties.sv
`timescale 1ns/1ps
`default_nettype none

module thread_manager_properties (
  input wire logic clk,
  input wire logic rst,
  input wire logic [7:0] ctl_state_i,
  input wire logic [3:0] cmd_i,
  input wire logic [1:0] rslt_i,
  input wire logic dispatch_i
);

  int error_count = 0;
  logic cmd_seen;

  assign cmd_seen = (ctl_state_i == thread_mgr_pkg::CTL_CPU_CMD) &&
    (cmd_i == thread_mgr_pkg::THREAD_CMD_RUN || cmd_i == thread_mgr_pkg::THREAD_CMD_STOP);

  one_cycle_dispatch: assert property (@(posedge clk) disable iff (rst)
    dispatch_i |=> !dispatch_i)
    else begin
      error_count++;
      $error("dispatch_o stayed high for two cycles");
    end

  no_stray_result: assert property (@(posedge clk) disable iff (rst)
    !cmd_seen |=> rslt_i == thread_mgr_pkg::RSLT_NONE)
    else begin
      error_count++;
      $error("thrd_rslt_o active without a RUN or STOP command");
    end

  quiet_after_reset: assert property (@(posedge clk)
    rst |=> !dispatch_i && rslt_i == thread_mgr_pkg::RSLT_NONE)
    else begin
      error_count++;
      $error("Control outputs active in the cycle after reset");
    end

endmodule

bind thread_manager thread_manager_properties i_props (
  .clk(clk),
  .rst(rst),
  .ctl_state_i(ctl_state_i),
  .cmd_i(thrd_cmd_i),
  .rslt_i(thrd_rslt_o),
  .dispatch_i(dispatch_o)
);

`default_nettype wire

// File: thread_manager.sv
`timescale 1ns/1ps
`default_nettype none

module thread_manager (
  input wire logic clk,
  input wire logic rst,
  input wire logic [7:0] ctl_state_i,
  input wire logic [3:0] thrd_cmd_i,
  input wire logic [thread_mgr_pkg::DATA_W-1:0] data_i,
  input wire logic [thread_mgr_pkg::ADDR_W-1:0] addr_i,
  output logic [1:0] thrd_rslt_o,
  output logic [thread_mgr_pkg::DATA_W-1:0] result_data_o,
  output logic [thread_mgr_pkg::ADDR_W-1:0] next_proc_o,
  output logic [thread_mgr_pkg::DATA_W-1:0] next_state_o,
  output logic dispatch_o
);

  thread_entry_if push ();
  thread_entry_if pop ();

  logic append;
  logic [thread_mgr_pkg::DATA_W-1:0] append_state;
  logic [thread_mgr_pkg::ADDR_W-1:0] append_addr;
  logic remove;
  logic [thread_mgr_pkg::ADDR_W-1:0] remove_addr;
  logic pick;
  logic free;
  logic pick_valid;
  logic [thread_mgr_pkg::DATA_W-1:0] pick_state;
  logic [thread_mgr_pkg::ADDR_W-1:0] pick_addr;

  thread_cmd_decoder i_decoder (
    .clk(clk),
    .rst(rst),
    .ctl_state_i(ctl_state_i),
    .thrd_cmd_i(thrd_cmd_i),
    .data_i(data_i),
    .addr_i(addr_i),
    .thrd_rslt_o(thrd_rslt_o),
    .result_data_o(result_data_o),
    .push(push.producer)
  );

  pending_queue i_pending (
    .clk(clk),
    .rst(rst),
    .push(push.consumer),
    .pop(pop.producer)
  );

  active_table i_active (
    .clk(clk),
    .rst(rst),
    .append_i(append),
    .append_state_i(append_state),
    .append_addr_i(append_addr),
    .remove_i(remove),
    .remove_addr_i(remove_addr),
    .pick_i(pick),
    .free_o(free),
    .pick_valid_o(pick_valid),
    .pick_state_o(pick_state),
    .pick_addr_o(pick_addr)
  );

  thread_dispatcher i_dispatcher (
    .clk(clk),
    .rst(rst),
    .ctl_state_i(ctl_state_i),
    .thrd_cmd_i(thrd_cmd_i),
    .pop(pop.consumer),
    .append_o(append),
    .append_state_o(append_state),
    .append_addr_o(append_addr),
    .remove_o(remove),
    .remove_addr_o(remove_addr),
    .pick_o(pick),
    .free_i(free),
    .pick_valid_i(pick_valid),
    .pick_state_i(pick_state),
    .pick_addr_i(pick_addr),
    .next_proc_o(next_proc_o),
    .next_state_o(next_state_o),
    .dispatch_o(dispatch_o)
  );

endmodule

`default_nettype wire

// File: thread_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module thread_dispatcher (
  input wire logic clk,
  input wire logic rst,
  input wire logic [7:0] ctl_state_i,
  input wire logic [3:0] thrd_cmd_i,
  thread_entry_if.consumer pop,
  output logic append_o,
  output logic [thread_mgr_pkg::DATA_W-1:0] append_state_o,
  output logic [thread_mgr_pkg::ADDR_W-1:0] append_addr_o,
  output logic remove_o,
  output logic [thread_mgr_pkg::ADDR_W-1:0] remove_addr_o,
  output logic pick_o,
  input wire logic free_i,
  input wire logic pick_valid_i,
  input wire logic [thread_mgr_pkg::DATA_W-1:0] pick_state_i,
  input wire logic [thread_mgr_pkg::ADDR_W-1:0] pick_addr_i,
  output logic [thread_mgr_pkg::ADDR_W-1:0] next_proc_o,
  output logic [thread_mgr_pkg::DATA_W-1:0] next_state_o,
  output logic dispatch_o
);

  logic ready;
  logic decide;
  logic promote;
  logic stop;

  assign decide = ready && (ctl_state_i == thread_mgr_pkg::CTL_CPU_LOOP);

  // Pending work first. A RUN head waits while the table is full.
  assign promote = decide && pop.valid && !pop.is_stop && free_i;
  assign stop = decide && pop.valid && pop.is_stop;
  assign pick_o = decide && !promote && !stop;

  assign pop.take = promote || stop;
  assign pop.full = 1'b0;  // Only meaningful on the push side.

  assign append_o = promote;
  assign append_state_o = pop.state;
  assign append_addr_o = pop.addr;
  assign remove_o = stop;
  assign remove_addr_o = pop.addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      ready <= 1'b1;
    end else if (decide) begin
      ready <= 1'b0;  // A GET_NEXT in this cycle is not kept.
    end else if (thrd_cmd_i == thread_mgr_pkg::THREAD_CMD_GET_NEXT) begin
      ready <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dispatch_o <= 1'b0;
      next_proc_o <= '0;
      next_state_o <= '0;
    end else begin
      dispatch_o <= promote || (pick_o && pick_valid_i);
      if (promote) begin
        next_proc_o <= pop.addr;
        next_state_o <= pop.state;
      end else if (pick_o && pick_valid_i) begin
        next_proc_o <= pick_addr_i;
        next_state_o <= pick_state_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: active_table.sv
`timescale 1ns/1ps
`default_nettype none

module active_table (
  input wire logic clk,
  input wire logic rst,
  input wire logic append_i,
  input wire logic [thread_mgr_pkg::DATA_W-1:0] append_state_i,
  input wire logic [thread_mgr_pkg::ADDR_W-1:0] append_addr_i,
  input wire logic remove_i,
  input wire logic [thread_mgr_pkg::ADDR_W-1:0] remove_addr_i,
  input wire logic pick_i,
  output logic free_o,
  output logic pick_valid_o,
  output logic [thread_mgr_pkg::DATA_W-1:0] pick_state_o,
  output logic [thread_mgr_pkg::ADDR_W-1:0] pick_addr_o
);

  logic [thread_mgr_pkg::PROC_QUANTITY-1:0] slot_valid;
  logic [thread_mgr_pkg::DATA_W-1:0] slot_state [thread_mgr_pkg::PROC_QUANTITY];
  logic [thread_mgr_pkg::ADDR_W-1:0] slot_addr [thread_mgr_pkg::PROC_QUANTITY];

  logic [thread_mgr_pkg::SLOT_W-1:0] free_idx;
  logic [thread_mgr_pkg::SLOT_W-1:0] pick_idx;
  logic [thread_mgr_pkg::SLOT_W-1:0] last_pick;

  function automatic logic [thread_mgr_pkg::SLOT_W-1:0] slot_after(
    input logic [thread_mgr_pkg::SLOT_W-1:0] base,
    input int offset
  );
    return thread_mgr_pkg::SLOT_W'((int'(base) + offset) % thread_mgr_pkg::PROC_QUANTITY);
  endfunction

  // Lowest free slot, scanned from the top so the smallest index wins.
  always_comb begin
    free_o = 1'b0;
    free_idx = '0;
    for (int i = thread_mgr_pkg::PROC_QUANTITY - 1; i >= 0; i--) begin
      if (!slot_valid[i]) begin
        free_o = 1'b1;
        free_idx = thread_mgr_pkg::SLOT_W'(i);
      end
    end
  end

  // Rotating priority starting just after the last pick.
  always_comb begin
    pick_valid_o = 1'b0;
    pick_idx = last_pick;
    for (int i = thread_mgr_pkg::PROC_QUANTITY; i >= 1; i--) begin
      if (slot_valid[slot_after(last_pick, i)]) begin
        pick_valid_o = 1'b1;
        pick_idx = slot_after(last_pick, i);
      end
    end
  end

  assign pick_state_o = slot_state[pick_idx];
  assign pick_addr_o = slot_addr[pick_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_valid <= '0;
      last_pick <= thread_mgr_pkg::SLOT_W'(thread_mgr_pkg::PROC_QUANTITY - 1);
    end else begin
      if (append_i && free_o) slot_valid[free_idx] <= 1'b1;
      if (remove_i) begin
        for (int i = 0; i < thread_mgr_pkg::PROC_QUANTITY; i++) begin
          if (slot_valid[i] && slot_addr[i] == remove_addr_i) slot_valid[i] <= 1'b0;
        end
      end
      if (pick_i && pick_valid_o) last_pick <= pick_idx;
    end
  end

  always_ff @(posedge clk) begin
    if (append_i && free_o) begin
      slot_state[free_idx] <= append_state_i;
      slot_addr[free_idx] <= append_addr_i;
    end
  end

endmodule

`default_nettype wire

// File: pending_queue.sv
`timescale 1ns/1ps
`default_nettype none

module pending_queue (
  input wire logic clk,
  input wire logic rst,
  thread_entry_if.consumer push,
  thread_entry_if.producer pop
);

  logic entry_stop [thread_mgr_pkg::PROC_QUANTITY];
  logic [thread_mgr_pkg::DATA_W-1:0] entry_state [thread_mgr_pkg::PROC_QUANTITY];
  logic [thread_mgr_pkg::ADDR_W-1:0] entry_addr [thread_mgr_pkg::PROC_QUANTITY];

  logic [thread_mgr_pkg::SLOT_W-1:0] pproc_b;  // Head.
  logic [thread_mgr_pkg::SLOT_W-1:0] pproc_e;  // Next free position.
  logic [thread_mgr_pkg::COUNT_W-1:0] count;
  logic push_fire;
  logic pop_fire;

  function automatic logic [thread_mgr_pkg::SLOT_W-1:0] next_ptr(
    input logic [thread_mgr_pkg::SLOT_W-1:0] ptr
  );
    if (ptr == thread_mgr_pkg::SLOT_W'(thread_mgr_pkg::PROC_QUANTITY - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push.full = (count == thread_mgr_pkg::COUNT_W'(thread_mgr_pkg::PROC_QUANTITY));
  assign push_fire = push.valid && !push.full;
  assign push.take = push_fire;
  assign pop_fire = pop.take && pop.valid;

  // Head is visible without a register stage.
  assign pop.valid = (count != '0);
  assign pop.is_stop = entry_stop[pproc_b];
  assign pop.state = entry_state[pproc_b];
  assign pop.addr = entry_addr[pproc_b];

  always_ff @(posedge clk) begin
    if (rst) begin
      pproc_b <= '0;
      pproc_e <= '0;
      count <= '0;
    end else begin
      if (push_fire) pproc_e <= next_ptr(pproc_e);
      if (pop_fire) pproc_b <= next_ptr(pproc_b);
      if (push_fire && !pop_fire) count <= count + 1'b1;
      else if (pop_fire && !push_fire) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push_fire) begin
      entry_stop[pproc_e] <= push.is_stop;
      entry_state[pproc_e] <= push.state;
      entry_addr[pproc_e] <= push.addr;
    end
  end

endmodule

`default_nettype wire

// File: thread_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module thread_cmd_decoder (
  input wire logic clk,
  input wire logic rst,
  input wire logic [7:0] ctl_state_i,
  input wire logic [3:0] thrd_cmd_i,
  input wire logic [thread_mgr_pkg::DATA_W-1:0] data_i,
  input wire logic [thread_mgr_pkg::ADDR_W-1:0] addr_i,
  output logic [1:0] thrd_rslt_o,
  output logic [thread_mgr_pkg::DATA_W-1:0] result_data_o,
  thread_entry_if.producer push
);

  logic in_cmd_state;
  logic is_run;
  logic is_stop;
  logic cmd_valid;

  assign in_cmd_state = (ctl_state_i == thread_mgr_pkg::CTL_CPU_CMD);
  assign is_run = (thrd_cmd_i == thread_mgr_pkg::THREAD_CMD_RUN);
  assign is_stop = (thrd_cmd_i == thread_mgr_pkg::THREAD_CMD_STOP);
  assign cmd_valid = in_cmd_state && (is_run || is_stop);

  // The queue stores the entry in this same cycle when it has room.
  assign push.valid = cmd_valid && !push.full;
  assign push.is_stop = is_stop;
  assign push.state = is_stop ? '0 : data_i;  // STOP carries no saved state.
  assign push.addr = addr_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      thrd_rslt_o <= thread_mgr_pkg::RSLT_NONE;
      result_data_o <= thread_mgr_pkg::STATE_NACK;
    end else if (cmd_valid) begin
      if (!push.full) begin
        thrd_rslt_o <= thread_mgr_pkg::RSLT_ACCEPTED;
        result_data_o <= thread_mgr_pkg::STATE_ACK;
      end else begin
        thrd_rslt_o <= thread_mgr_pkg::RSLT_REJECTED;
        result_data_o <= thread_mgr_pkg::STATE_NACK;
      end
    end else begin
      // Result is a single cycle pulse.
      thrd_rslt_o <= thread_mgr_pkg::RSLT_NONE;
      result_data_o <= thread_mgr_pkg::STATE_NACK;
    end
  end

endmodule

`default_nettype wire

// File: thread_entry_if.sv
`timescale 1ns/1ps
`default_nettype none

// One pending entry moving between the decoder, the queue and the dispatcher.
interface thread_entry_if;

  logic valid;
  logic take;
  logic is_stop;
  logic [thread_mgr_pkg::DATA_W-1:0] state;
  logic [thread_mgr_pkg::ADDR_W-1:0] addr;
  logic full;

  modport producer (
    output valid,
    output is_stop,
    output state,
    output addr,
    input take,
    input full
  );

  modport consumer (
    input valid,
    input is_stop,
    input state,
    input addr,
    output take,
    output full
  );

endinterface

`default_nettype wire

// File: thread_mgr_pkg.sv
`default_nettype none

package thread_mgr_pkg;

  // Data path widths.
  localparam int DATA_W = 32;
  localparam int ADDR_W = 16;

  // Both the pending queue and the active table hold this many threads.
  localparam int PROC_QUANTITY = 8;
  localparam int SLOT_W = 3;
  localparam int COUNT_W = SLOT_W + 1;  // Queue fill level, 0 to PROC_QUANTITY.

  // Controller states the manager reacts to.
  // Every other code leaves the manager idle.
  localparam logic [7:0] CTL_CPU_LOOP = 8'h05;
  localparam logic [7:0] CTL_CPU_CMD = 8'h06;

  // Thread commands from the CPU.
  localparam logic [3:0] THREAD_CMD_RUN = 4'h1;
  localparam logic [3:0] THREAD_CMD_STOP = 4'h2;
  localparam logic [3:0] THREAD_CMD_GET_NEXT = 4'h3;

  // Command result codes.
  localparam logic [1:0] RSLT_NONE = 2'd0;
  localparam logic [1:0] RSLT_ACCEPTED = 2'd1;
  localparam logic [1:0] RSLT_REJECTED = 2'd2;

  // Result data words returned with the result code.
  localparam logic [DATA_W-1:0] STATE_ACK = {DATA_W{1'b1}};
  localparam logic [DATA_W-1:0] STATE_NACK = {DATA_W{1'b0}};

endpackage

`default_nettype wire
